/* source/seq_est_pkg.sv */
package seq_est_pkg;

    localparam int SAMPLE_WIDTH = 8;
    localparam int B_LEN = 2;
    localparam int CHAN_DEPTH = 4;
    // Must cover at least CHAN_DEPTH - 1 past symbols
    localparam int SH_DEPTH = 8;
    localparam int N_S = 2 ** B_LEN;
    localparam int ENERGY_WIDTH = 16;

    localparam int TAP_ADDR_WIDTH = $clog2(CHAN_DEPTH);
    localparam int CNT_WIDTH = (B_LEN > 1) ? $clog2(B_LEN) : 1;
    localparam int SAMPLE_MAX = 2 ** (SAMPLE_WIDTH - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (SAMPLE_WIDTH - 1));
    localparam int ENERGY_MAX = 2 ** ENERGY_WIDTH - 1;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [1:0] symbol_t;
    typedef logic [ENERGY_WIDTH-1:0] energy_t;

    // Entry 0 is the older sample
    typedef struct packed {
        sample_t [B_LEN-1:0] s;
    } sample_block_t;

    // Entry 0 is the newest symbol
    typedef struct packed {
        symbol_t [B_LEN-1:0] sym;
    } symbol_block_t;

    typedef struct packed {
        energy_t energy;
        symbol_block_t symbols;
    } state_t;

    typedef state_t [N_S-1:0] state_array_t;

    // Tap 0 weights the current symbol
    typedef sample_t [CHAN_DEPTH-1:0] chan_taps_t;

    typedef enum logic {
        FILL,
        FULL
    } buf_state_e;

    function automatic sample_t sat_sample(input int v);
        if (v > SAMPLE_MAX) begin
            return sample_t'(SAMPLE_MAX);
        end
        if (v < SAMPLE_MIN) begin
            return sample_t'(SAMPLE_MIN);
        end
        return sample_t'(v);
    endfunction

endpackage

/* source/channel_store.sv */
`timescale 1ns/1ps

module channel_store
    import seq_est_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      tap_we,
    input  logic [TAP_ADDR_WIDTH-1:0] tap_addr,
    input  sample_t                   tap_data,
    output chan_taps_t                taps
);

    // One tap written per strobe, all taps visible at once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taps <= '0;
        end else if (tap_we) begin
            taps[tap_addr] <= tap_data;
        end
    end

endmodule

/* source/sample_block_buffer.sv */
`timescale 1ns/1ps

module sample_block_buffer
    import seq_est_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          sample_valid,
    input  sample_t       sample,
    output logic          run,
    output sample_block_t rx_neg
);

    buf_state_e state;
    buf_state_e state_next;
    logic [CNT_WIDTH-1:0] count;
    logic last;

    // The last sample of a block goes straight into rx_neg
    sample_t [B_LEN-2:0] slots;

    assign last = sample_valid && (count == CNT_WIDTH'(B_LEN - 1));

    assign state_next = last ? FULL : FILL;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FILL;
            count <= '0;
            rx_neg <= '0;
        end else begin
            state <= state_next;
            if (last) begin
                count <= '0;
                for (int p = 0; p < B_LEN; p++) begin
                    if (p == B_LEN - 1) begin
                        rx_neg.s[p] <= sat_sample(-int'(sample));
                    end else begin
                        rx_neg.s[p] <= sat_sample(-int'(slots[p]));
                    end
                end
            end else if (sample_valid) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid && !last) begin
            slots[count] <= sample;
        end
    end

    assign run = (state == FULL);

    a_run_single: assert property (@(posedge clk) disable iff (!rst_n) run |=> !run)
        else $error("run held high for more than one cycle");

endmodule

/* source/conv_unit.sv */
`timescale 1ns/1ps

module conv_unit
    import seq_est_pkg::*;
#(
    parameter int OFFSET = 1
) (
    input  symbol_t [SH_DEPTH-1:0] hist,
    input  chan_taps_t             taps,
    output sample_block_t          out
);

    // Position p sees past symbol j - p - OFFSET through tap j
    always_comb begin
        int acc;
        int k;
        for (int p = 0; p < B_LEN; p++) begin
            acc = 0;
            for (int j = 0; j < CHAN_DEPTH; j++) begin
                k = j - p - OFFSET;
                if (k >= 0 && k < SH_DEPTH) begin
                    acc += int'(taps[j]) * int'(hist[k]);
                end
            end
            out.s[p] = sat_sample(acc);
        end
    end

endmodule

/* source/state_metric_unit.sv */
`timescale 1ns/1ps

module state_metric_unit
    import seq_est_pkg::*;
(
    input  chan_taps_t    taps,
    input  sample_block_t precomputed_static,
    output state_array_t  states
);

    // Bit p of hyp set means block position p (0 is older) carries +1
    function automatic state_t eval_hyp(
        input logic [B_LEN-1:0] hyp,
        input chan_taps_t       t,
        input sample_block_t    ps
    );
        state_t st;
        symbol_t [B_LEN-1:0] pos_sym;
        int res;
        int total;
        total = 0;
        for (int p = 0; p < B_LEN; p++) begin
            pos_sym[p] = hyp[p] ? 2'sd1 : -2'sd1;
        end
        for (int p = 0; p < B_LEN; p++) begin
            res = int'(ps.s[p]);
            // In-block interference, earlier positions only
            for (int j = 0; j < CHAN_DEPTH; j++) begin
                if (p - j >= 0) begin
                    res += int'(t[j]) * int'(pos_sym[p - j]);
                end
            end
            total += res * res;
        end
        if (total > ENERGY_MAX) begin
            st.energy = energy_t'(ENERGY_MAX);
        end else begin
            st.energy = energy_t'(total);
        end
        // Newest symbol first
        for (int e = 0; e < B_LEN; e++) begin
            st.symbols.sym[e] = pos_sym[B_LEN - 1 - e];
        end
        return st;
    endfunction

    always_comb begin
        for (int i = 0; i < N_S; i++) begin
            states[i] = eval_hyp(B_LEN'(i), taps, precomputed_static);
        end
    end

endmodule

/* source/static_select_unit.sv */
`timescale 1ns/1ps

module static_select_unit
    import seq_est_pkg::*;
(
    input  state_array_t states,
    output state_t       best
);

    // Strict compare keeps the lower index on a tie
    always_comb begin
        best = states[0];
        for (int i = 1; i < N_S; i++) begin
            if (states[i].energy < best.energy) begin
                best = states[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N_S; i++) begin
            a_best_min: assert final (best.energy <= states[i].energy)
                else $error("selected energy %h exceeds state %0d energy %h",
                            best.energy, i, states[i].energy);
        end
    end

endmodule

/* source/global_static_unit.sv */
`timescale 1ns/1ps

module global_static_unit
    import seq_est_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          run,
    input  chan_taps_t    taps,
    input  sample_block_t rx_neg,
    input  state_t        best,
    output sample_block_t precomputed_static,
    output symbol_block_t decisions,
    output energy_t       decision_energy,
    output logic          decision_valid
);

    // Newest decided symbol at index 0
    symbol_t [SH_DEPTH-1:0] hist;
    sample_block_t static_val;

    function automatic logic is_antipodal(input symbol_t [B_LEN-1:0] s);
        for (int e = 0; e < B_LEN; e++) begin
            if (s[e] != 2'sd1 && s[e] != -2'sd1) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // First block sample sits one step after the newest history entry
    conv_unit #(
        .OFFSET(1)
    ) u_conv (
        .hist(hist),
        .taps(taps),
        .out (static_val)
    );

    always_comb begin
        for (int p = 0; p < B_LEN; p++) begin
            precomputed_static.s[p] = sat_sample(int'(static_val.s[p]) + int'(rx_neg.s[p]));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist <= '0;
            decision_energy <= '0;
            decision_valid <= 1'b0;
        end else begin
            decision_valid <= run;
            if (run) begin
                hist <= {hist[SH_DEPTH-B_LEN-1:0], best.symbols.sym};
                decision_energy <= best.energy;
            end
        end
    end

    assign decisions = symbol_block_t'(hist[B_LEN-1:0]);

    a_hist_antipodal: assert property (@(posedge clk) disable iff (!rst_n)
        run |=> is_antipodal(hist[B_LEN-1:0]))
        else $error("history low entries not +1/-1 after run");

endmodule

/* source/seq_est_top.sv */
`timescale 1ns/1ps

module seq_est_top
    import seq_est_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      tap_we,
    input  logic [TAP_ADDR_WIDTH-1:0] tap_addr,
    input  sample_t                   tap_data,
    input  logic                      sample_valid,
    input  sample_t                   sample,
    output logic                      decision_valid,
    output symbol_block_t             decisions,
    output energy_t                   decision_energy,
    output sample_block_t             precomputed_static
);

    chan_taps_t taps;
    logic run;
    sample_block_t rx_neg;
    state_array_t states;
    state_t best;

    channel_store u_chan (
        .clk     (clk),
        .rst_n   (rst_n),
        .tap_we  (tap_we),
        .tap_addr(tap_addr),
        .tap_data(tap_data),
        .taps    (taps)
    );

    sample_block_buffer u_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_valid(sample_valid),
        .sample      (sample),
        .run         (run),
        .rx_neg      (rx_neg)
    );

    global_static_unit u_gsu (
        .clk               (clk),
        .rst_n             (rst_n),
        .run               (run),
        .taps              (taps),
        .rx_neg            (rx_neg),
        .best              (best),
        .precomputed_static(precomputed_static),
        .decisions         (decisions),
        .decision_energy   (decision_energy),
        .decision_valid    (decision_valid)
    );

    state_metric_unit u_smu (
        .taps              (taps),
        .precomputed_static(precomputed_static),
        .states            (states)
    );

    static_select_unit u_ssu (
        .states(states),
        .best  (best)
    );

    // Taps feed every block in progress, so writes wait for an idle stream
    a_tap_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tap_we |-> !sample_valid && !run && !decision_valid)
        else $error("channel tap written while a block is in flight");

endmodule

/* bench/seq_est_tb.sv */
`timescale 1ns/1ps

module seq_est_tb
    import seq_est_pkg::*;
();

    localparam int N_IDENT = 200;
    localparam int N_ISI = 200;
    localparam int N_GAP = 100;
    localparam int N_NOISE = 20;
    // Gap blocks may take two cycles per sample
    localparam int MAX_CYCLES = N_IDENT + N_ISI + 2 * N_GAP + N_NOISE + 100;

    typedef struct packed {
        symbol_block_t dec;
        energy_t       energy;
        sample_block_t stat;
        logic          check;
    } expect_t;

    logic clk, rst_n, tap_we, sample_valid, decision_valid;
    logic [TAP_ADDR_WIDTH-1:0] tap_addr;
    sample_t tap_data, sample;
    symbol_block_t decisions;
    energy_t decision_energy;
    sample_block_t precomputed_static;

    // Last sample of a block, with its expected results delayed to the DUT latency
    logic last_mark, mark_d1, mark_d2;
    expect_t blk_exp, exp_d1, exp_d2;

    int model_taps[CHAN_DEPTH];
    int tx_q[$];
    logic [31:0] rng;
    int errors, blocks, cycles;

    seq_est_top u_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        mark_d1 <= last_mark;
        mark_d2 <= mark_d1;
        exp_d1 <= blk_exp;
        exp_d2 <= exp_d1;
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Cycle limit of %0d reached before the tests finished", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !decision_valid && decision_energy == '0)
        else begin
            errors++;
            $display("mismatch after reset: decision_valid %h decision_energy %h, expected 0 and 0",
                     $sampled(decision_valid), $sampled(decision_energy));
        end

    // One pulse per block, two edges after its last sample
    a_cadence: assert property (@(posedge clk) disable iff (!rst_n) decision_valid == mark_d2)
        else begin
            errors++;
            $display("mismatch decision_valid: got %h expected %h",
                     $sampled(decision_valid), $sampled(mark_d2));
        end

    a_decision: assert property (@(posedge clk) disable iff (!rst_n)
        decision_valid && exp_d2.check |-> decisions == exp_d2.dec
            && decision_energy == exp_d2.energy)
        else begin
            errors++;
            $display("mismatch decisions %h decision_energy %h: expected %h and %h",
                     $sampled(decisions), $sampled(decision_energy),
                     $sampled(exp_d2.dec), $sampled(exp_d2.energy));
        end

    a_static: assert property (@(posedge clk) disable iff (!rst_n)
        mark_d1 |-> precomputed_static == exp_d1.stat)
        else begin
            errors++;
            $display("mismatch precomputed_static: got %h expected %h",
                     $sampled(precomputed_static), $sampled(exp_d1.stat));
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int clamp_sample(input int v);
        return (v > SAMPLE_MAX) ? SAMPLE_MAX : ((v < SAMPLE_MIN) ? SAMPLE_MIN : v);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            sample_valid = 1'b0;
            last_mark = 1'b0;
        end
    endtask

    // Channel history restarts from silence together with the DUT
    task automatic apply_reset();
        rst_n = 1'b0;
        tx_q.delete();
        repeat (SH_DEPTH + B_LEN) tx_q.push_back(0);
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic load_taps(input int t0, input int t1, input int t2, input int t3);
        int vals[CHAN_DEPTH];
        vals = '{t0, t1, t2, t3};
        for (int j = 0; j < CHAN_DEPTH; j++) begin
            @(posedge clk);
            #1;
            tap_we = 1'b1;
            tap_addr = TAP_ADDR_WIDTH'(j);
            tap_data = sample_t'(vals[j]);
            model_taps[j] = vals[j];
        end
        @(posedge clk);
        #1;
        tap_we = 1'b0;
    endtask

    task automatic send_block(input bit gaps, input int noise_pos, input int noise, input bit check);
        int sym[B_LEN];
        int clean[B_LEN];
        int rx[B_LEN];
        int isi;
        int energy;
        energy = 0;
        for (int p = 0; p < B_LEN; p++) begin
            rng = xorshift32(rng);
            if (gaps && rng[8]) begin
                idle_cycles(1);
            end
            sym[p] = rng[0] ? 1 : -1;
            tx_q.push_front(sym[p]);
            void'(tx_q.pop_back());
            clean[p] = 0;
            for (int j = 0; j < CHAN_DEPTH; j++) begin
                clean[p] += model_taps[j] * tx_q[j];
            end
            rx[p] = clamp_sample(clean[p] + ((p == noise_pos) ? noise : 0));
            @(posedge clk);
            #1;
            sample_valid = 1'b1;
            sample = sample_t'(rx[p]);
            last_mark = (p == B_LEN - 1);
        end
        // Past symbols sit behind the block in the transmit queue
        for (int p = 0; p < B_LEN; p++) begin
            isi = 0;
            for (int j = p + 1; j < CHAN_DEPTH; j++) begin
                isi += model_taps[j] * tx_q[B_LEN + j - p - 1];
            end
            blk_exp.stat.s[p] = sample_t'(clamp_sample(isi - rx[p]));
            energy += (clean[p] - rx[p]) * (clean[p] - rx[p]);
            blk_exp.dec.sym[p] = symbol_t'(sym[B_LEN - 1 - p]);
        end
        blk_exp.energy = energy_t'(energy);
        blk_exp.check = check;
        blocks++;
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        tap_we = 1'b0;
        tap_addr = '0;
        tap_data = '0;
        sample_valid = 1'b0;
        sample = '0;
        last_mark = 1'b0;
        blk_exp = '0;
        rng = 32'habee;
        errors = 0;
        blocks = 0;
        cycles = 0;
        apply_reset();
        load_taps(40, 0, 0, 0);
        repeat (N_IDENT / B_LEN) send_block(1'b0, -1, 0, 1'b1);
        idle_cycles(4);
        apply_reset();
        load_taps(30, 12, -6, 3);
        send_block(1'b0, -1, 0, 1'b0);
        repeat (N_ISI / B_LEN - 1) send_block(1'b0, -1, 0, 1'b1);
        repeat (N_GAP / B_LEN) send_block(1'b1, -1, 0, 1'b1);
        // Offset of 5 on the newer sample of one block
        for (int b = 0; b < N_NOISE / B_LEN; b++) begin
            send_block(1'b0, (b == 5) ? 1 : -1, 5, 1'b1);
        end
        idle_cycles(4);
        $display("Blocks sent: %0d, errors: %0d", blocks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* compile.f */
source/seq_est_pkg.sv
source/channel_store.sv
source/sample_block_buffer.sv
source/conv_unit.sv
source/state_metric_unit.sv
source/static_select_unit.sv
source/global_static_unit.sv
source/seq_est_top.sv
bench/seq_est_tb.sv
